// File: filelist.f
udp_pkg.sv
sync_fifo.sv
udp_header_parser.sv
udp_checksum.sv
udp_payload_gate.sv
udp_reader_top.sv
udp_reader_properties.sv
tb_udp_reader.sv

// File: run.sh
#!/bin/sh
# Compile and run the UDP reader testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_udp_reader -f filelist.f

# the log decides the result, so a fatal exit must not stop the script here.
./obj_dir/Vtb_udp_reader > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation result: ok"
    exit 0
else
    echo "simulation result: failing"
    exit 1
fi

// File: tb_udp_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_reader;

    typedef enum logic [2:0] {
        cor_none, cor_zero_cks, cor_flip_cks, cor_bad_proto, cor_bad_ver,
        cor_eof_early, cor_eof_late
    } corrupt_t;

    // payload length, payload seed, corruption, accepted.
    typedef struct packed {
        logic [10:0] len;
        logic [31:0] seed;
        corrupt_t    kind;
        logic        ok;
    } frame_desc_t;

    localparam logic [31:0] rand_seed = 32'hcd0ccda6;
    localparam int wait_limit = 20000;
    localparam int num_frames = 17;
    localparam frame_desc_t frames [num_frames] = '{
        '{11'd0,    32'h0000_0001, cor_none,      1'b1},
        '{11'd1,    32'h0000_0002, cor_none,      1'b1},
        '{11'd37,   32'h0000_0003, cor_none,      1'b1},
        '{11'd64,   32'h0000_0004, cor_none,      1'b1},
        '{11'd1024, 32'h0000_0005, cor_none,      1'b1},
        '{11'd20,   32'h0000_0006, cor_zero_cks,  1'b1},
        '{11'd15,   32'h0000_0007, cor_flip_cks,  1'b0},
        '{11'd16,   32'h0000_0008, cor_none,      1'b1},
        '{11'd12,   32'h0000_0009, cor_bad_proto, 1'b0},
        '{11'd9,    32'h0000_000a, cor_bad_ver,   1'b0},
        '{11'd33,   32'h0000_000b, cor_none,      1'b1},
        '{11'd40,   32'h0000_000c, cor_eof_early, 1'b0},
        '{11'd7,    32'h0000_000d, cor_none,      1'b1},
        '{11'd25,   32'h0000_000e, cor_eof_late,  1'b0},
        '{11'd200,  32'h0000_000f, cor_none,      1'b1},
        '{11'd0,    32'h0000_0010, cor_eof_early, 1'b0},
        '{11'd3,    32'h0000_0011, cor_none,      1'b1}
    };

    logic              clock;
    logic              rst_n;
    logic              in_wr_en;
    udp_pkg::in_beat_t in_din;
    logic              in_full;
    logic              out_rd_en;
    logic [7:0]        out_dout;
    logic              out_empty;

    // frame under construction and the payload bytes still owed.
    logic [7:0] frm [0:1055];
    int         frm_len;
    logic [7:0] exp_q [$];

    udp_reader_top u_dut (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_wr_en (in_wr_en),
        .in_din   (in_din),
        .in_full  (in_full),
        .out_rd_en(out_rd_en),
        .out_dout (out_dout),
        .out_empty(out_empty)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h",
                                $time, name, got, expected));
        end
    endtask

    task automatic put16(input int ofs, input logic [15:0] value);
        frm[ofs]     = value[15:8];
        frm[ofs + 1] = value[7:0];
    endtask

    // ones-complement sum over pseudo-header, UDP header and payload.
    function automatic logic [15:0] udp_checksum_of(input int n);
        logic [31:0] acc;
        logic [15:0] word;
        logic [15:0] cks;
        // protocol and UDP length of the pseudo-header, addresses come from the frame.
        acc = 32'h0000_0011 + 32'(n + 8);
        for (int i = 12; i < 28 + n; i += 2) begin
            word = {frm[i], (i + 1 < 28 + n) ? frm[i + 1] : 8'h00};
            acc  = acc + 32'(word);
        end
        while (acc[31:16] != 16'h0000) begin
            acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        end
        cks = ~acc[15:0];
        return (cks == 16'h0000) ? 16'hffff : cks;
    endfunction

    task automatic build_frame(input frame_desc_t d);
        logic [31:0] st;
        logic [15:0] cks;
        int          n;
        n  = int'(d.len);
        st = rand_seed ^ d.seed;
        for (int i = 0; i < 28; i++) begin
            frm[i] = 8'h00;
        end
        // IPv4 header without options, then the UDP header.
        frm[0] = 8'h45;
        put16(2, 16'(n + 28));
        frm[8] = 8'h40;
        frm[9] = 8'd17;
        put16(12, 16'hc0a8);
        put16(14, 16'h0001);
        put16(16, 16'hc0a8);
        put16(18, 16'h0002);
        put16(20, 16'h04d2);
        put16(22, 16'h162e);
        put16(24, 16'(n + 8));
        for (int i = 0; i < n; i++) begin
            st = xorshift(st);
            frm[28 + i] = st[7:0];
            if (d.ok) begin
                exp_q.push_back(st[7:0]);
            end
        end
        cks = udp_checksum_of(n);
        case (d.kind)
            cor_zero_cks:  cks = 16'h0000;
            // a flip that lands on zero would mean no checksum.
            cor_flip_cks:  cks = (cks == 16'h0001) ? 16'h0003 : (cks ^ 16'h0001);
            cor_bad_proto: frm[9] = 8'd6;
            cor_bad_ver:   frm[0] = 8'h46;
            default:       ;
        endcase
        put16(26, cks);
        frm_len = n + 28;
        if (d.kind == cor_eof_early) begin
            frm_len = n + 27;
        end else if (d.kind == cor_eof_late) begin
            frm[n + 28] = 8'ha5;
            frm_len     = n + 29;
        end
    endtask

    task automatic send_frame();
        int waited;
        for (int i = 0; i < frm_len; i++) begin
            waited = 0;
            while (in_full) begin
                in_wr_en = 1'b0;
                waited++;
                if (waited > wait_limit) begin
                    abort_run("timeout: input FIFO stayed full");
                end
                @(negedge clock);
            end
            in_wr_en = 1'b1;
            in_din   = '{data: frm[i], sof: (i == 0), eof: (i == frm_len - 1)};
            @(negedge clock);
        end
        in_wr_en = 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin : reader
        logic [31:0] rs;
        logic [7:0]  exp_byte;
        rs        = rand_seed;
        out_rd_en = 1'b0;
        forever begin
            @(negedge clock);
            rs        = xorshift(rs);
            out_rd_en = 1'b0;
            if (rst_n && !out_empty) begin
                if (exp_q.size() == 0) begin
                    abort_run("output byte appeared with no accepted payload pending");
                end else if (rs[1:0] == 2'b00) begin
                    // sparse reads, about one cycle in four.
                    exp_byte = exp_q.pop_front();
                    compare_value("out_dout", 32'(out_dout), 32'(exp_byte));
                    out_rd_en = 1'b1;
                end
            end
        end
    end

    initial begin : main_seq
        int waited;
        rst_n    = 1'b0;
        in_wr_en = 1'b0;
        in_din   = '0;
        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        // output hidden and input open before any traffic.
        repeat (5) begin
            @(negedge clock);
            compare_value("out_empty", 32'(out_empty), 32'd1);
            compare_value("in_full", 32'(in_full), 32'd0);
        end
        for (int f = 0; f < num_frames; f++) begin
            build_frame(frames[f]);
            send_frame();
        end
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run($sformatf("timeout: %0d payload bytes never arrived",
                                    exp_q.size()));
            end
            @(negedge clock);
        end
        // the reader flags any stray byte during this idle stretch.
        repeat (100) @(negedge clock);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_reader_properties.sv
`timescale 1ns/1ps
`default_nettype none

module udp_reader_properties (
    input logic              clock,
    input logic              rst_n,
    input logic              in_full,
    input logic              in_pop,
    input logic              out_rd_en,
    input logic              out_empty,
    input udp_pkg::verdict_t verdict
);

    // output stays hidden for five cycles out of reset.
    a_empty_after_reset: assert property (
        @(posedge clock) rst_n && !$past(rst_n, 5) |-> out_empty
    ) else $error("out_empty dropped right after reset");

    a_no_pop_when_empty: assert property (
        @(posedge clock) disable iff (!rst_n) out_rd_en |-> !out_empty
    ) else $error("output read while out_empty is high");

    // only a parser pop lowers the level of a full input FIFO.
    a_full_holds: assert property (
        @(posedge clock) disable iff (!rst_n) in_full && !in_pop |=> in_full
    ) else $error("input FIFO level changed while full with no pop");

    a_verdict_pulse: assert property (
        @(posedge clock) disable iff (!rst_n) verdict.valid |=> !verdict.valid
    ) else $error("verdict valid held longer than one cycle");

endmodule

bind udp_reader_top udp_reader_properties u_properties (
    .clock    (clock),
    .rst_n    (rst_n),
    .in_full  (in_full),
    .in_pop   (fifo_rd_en),
    .out_rd_en(out_rd_en),
    .out_empty(out_empty),
    .verdict  (verdict)
);

`default_nettype wire

// File: udp_reader_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_reader_top (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              in_wr_en,
    input  udp_pkg::in_beat_t in_din,
    output logic              in_full,
    input  logic              out_rd_en,
    output logic [7:0]        out_dout,
    output logic              out_empty
);

    // input FIFO to parser.
    logic              fifo_rd_en;
    udp_pkg::in_beat_t fifo_dout;
    logic              fifo_empty;

    // parser to checksum and gate.
    udp_pkg::csum_beat_t csum_beat;
    udp_pkg::pay_beat_t  pay_beat;
    udp_pkg::verdict_t   verdict;
    logic                gate_busy;
    logic                gate_full;

    sync_fifo #(
        .entry_t(udp_pkg::in_beat_t),
        .depth  (udp_pkg::IN_FIFO_DEPTH)
    ) u_in_fifo (
        .clock(clock),
        .rst_n(rst_n),
        .flush(1'b0),
        .wr_en(in_wr_en),
        .din  (in_din),
        .full (in_full),
        .rd_en(fifo_rd_en),
        .dout (fifo_dout),
        .empty(fifo_empty)
    );

    udp_header_parser u_parser (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_rd_en (fifo_rd_en),
        .in_dout  (fifo_dout),
        .in_empty (fifo_empty),
        .gate_busy(gate_busy),
        .gate_full(gate_full),
        .csum     (csum_beat),
        .payload  (pay_beat)
    );

    udp_checksum u_checksum (
        .clock  (clock),
        .rst_n  (rst_n),
        .beat   (csum_beat),
        .verdict(verdict)
    );

    udp_payload_gate u_gate (
        .clock    (clock),
        .rst_n    (rst_n),
        .payload  (pay_beat),
        .verdict  (verdict),
        .busy     (gate_busy),
        .full     (gate_full),
        .out_rd_en(out_rd_en),
        .out_dout (out_dout),
        .out_empty(out_empty)
    );

endmodule

`default_nettype wire

// File: udp_payload_gate.sv
`timescale 1ns/1ps
`default_nettype none

module udp_payload_gate (
    input  logic               clock,
    input  logic               rst_n,
    input  udp_pkg::pay_beat_t payload,
    input  udp_pkg::verdict_t  verdict,
    output logic               busy,
    output logic               full,
    input  logic               out_rd_en,
    output logic [7:0]         out_dout,
    output logic               out_empty
);

    logic released;
    logic busy_q;
    logic flush;
    logic fifo_rd_en;
    logic fifo_empty;

    // a rejected frame is dropped from the buffer at once.
    assign flush = verdict.valid && !verdict.ok;

    // the buffer looks empty until the frame is accepted.
    assign out_empty  = !released || fifo_empty;
    assign fifo_rd_en = out_rd_en && released;

    // covers the first payload byte before busy_q catches up.
    assign busy = payload.valid || busy_q;

    sync_fifo #(
        .entry_t(logic [7:0]),
        .depth  (udp_pkg::OUT_FIFO_DEPTH)
    ) u_out_fifo (
        .clock(clock),
        .rst_n(rst_n),
        .flush(flush),
        .wr_en(payload.valid),
        .din  (payload.data),
        .full (full),
        .rd_en(fifo_rd_en),
        .dout (out_dout),
        .empty(fifo_empty)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            released <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            if (flush) begin
                released <= 1'b0;
            end else if (verdict.valid) begin
                released <= 1'b1;
            end else if (released && fifo_empty) begin
                released <= 1'b0;
            end
            // busy ends once the frame is drained or dropped.
            if (flush || (released && fifo_empty)) begin
                busy_q <= 1'b0;
            end else if (payload.valid) begin
                busy_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: udp_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module udp_checksum (
    input  logic                clock,
    input  logic                rst_n,
    input  udp_pkg::csum_beat_t beat,
    output udp_pkg::verdict_t   verdict
);

    // pseudo-header zero byte and protocol.
    localparam logic [15:0] seed = 16'(udp_pkg::IP_PROTO_UDP);

    logic [15:0] sum;
    logic [15:0] word;
    logic [15:0] sum_once;
    logic [15:0] sum_twice;
    logic [15:0] sum_next;
    logic [7:0]  hi_byte;
    logic        phase;
    logic        cks_nz;
    logic        cks_nz_next;

    // ones-complement add with end-around carry.
    function automatic logic [15:0] add_oc(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + 16'(s[16]);
    endfunction

    always_comb begin
        // an odd trailing byte is padded with zero.
        word        = phase ? {hi_byte, beat.data} : {beat.data, 8'h00};
        sum_once    = add_oc(sum, word);
        sum_twice   = add_oc(sum_once, word);
        sum_next    = beat.twice ? sum_twice : sum_once;
        cks_nz_next = cks_nz || (beat.cks_field && (beat.data != 8'h00));
    end

    always_ff @(posedge clock) begin
        if (beat.valid && !phase) begin
            hi_byte <= beat.data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sum     <= seed;
            phase   <= 1'b0;
            cks_nz  <= 1'b0;
            verdict <= '0;
        end else begin
            verdict.valid <= 1'b0;
            if (beat.valid) begin
                cks_nz <= cks_nz_next;
                if (beat.last) begin
                    verdict.valid <= 1'b1;
                    // a zero checksum field means no checksum was sent.
                    verdict.ok    <= !beat.bad && (!cks_nz_next || sum_next == 16'hffff);
                    sum           <= seed;
                    phase         <= 1'b0;
                    cks_nz        <= 1'b0;
                end else if (phase) begin
                    sum   <= sum_next;
                    phase <= 1'b0;
                end else begin
                    phase <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: udp_header_parser.sv
`timescale 1ns/1ps
`default_nettype none

module udp_header_parser (
    input  logic                clock,
    input  logic                rst_n,
    output logic                in_rd_en,
    input  udp_pkg::in_beat_t   in_dout,
    input  logic                in_empty,
    input  logic                gate_busy,
    input  logic                gate_full,
    output udp_pkg::csum_beat_t csum,
    output udp_pkg::pay_beat_t  payload
);

    typedef enum logic [2:0] {IDLE, IP_HDR, UDP_HDR, PAYLOAD, DISCARD} state_t;

    state_t      state;
    state_t      body_state;
    logic [10:0] cnt;
    logic [10:0] cnt_inc;
    logic [15:0] total_len;
    logic [7:0]  udp_len_hi;
    logic [15:0] udp_len;
    logic [7:0]  data;
    logic        in_frame;
    logic        is_final;
    logic        hdr_err;
    logic        len_err;
    logic        fail;

    // a new frame waits until the gate has drained the previous one.
    assign in_rd_en = !in_empty && !gate_full && !(in_dout.sof && gate_busy);

    assign data    = in_dout.data;
    assign udp_len = {udp_len_hi, data};
    assign cnt_inc = cnt + 11'd1;

    // in IDLE only a sof byte opens a frame, stray bytes are dropped.
    assign in_frame = (state == IDLE) ? in_dout.sof : (state != DISCARD);

    // total_len is current once the headers are past.
    assign is_final = (cnt >= 11'(udp_pkg::IPV4_HDR_LEN + udp_pkg::UDP_HDR_LEN - 1)) &&
                      ({5'd0, cnt} == total_len - 16'd1);
    // eof must land exactly on the last byte.
    assign len_err  = (in_dout.eof != is_final);
    assign fail     = hdr_err || len_err;

    always_comb begin
        hdr_err = 1'b0;
        if (cnt == 11'd0) begin
            hdr_err = (data != udp_pkg::IPV4_VER_IHL);
        end else if (cnt == 11'(udp_pkg::IP_PROTO_OFS)) begin
            hdr_err = (data != udp_pkg::IP_PROTO_UDP);
        end else if (cnt == 11'(udp_pkg::UDP_LEN_OFS + 1)) begin
            hdr_err = (udp_len < 16'(udp_pkg::UDP_HDR_LEN)) ||
                      (udp_len > 16'(udp_pkg::UDP_HDR_LEN + udp_pkg::OUT_FIFO_DEPTH)) ||
                      (total_len != udp_len + 16'(udp_pkg::IPV4_HDR_LEN));
        end
    end

    always_comb begin
        if (cnt_inc < 11'(udp_pkg::IPV4_HDR_LEN)) begin
            body_state = IP_HDR;
        end else if (cnt_inc < 11'(udp_pkg::IPV4_HDR_LEN + udp_pkg::UDP_HDR_LEN)) begin
            body_state = UDP_HDR;
        end else begin
            body_state = PAYLOAD;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            cnt        <= '0;
            total_len  <= '0;
            udp_len_hi <= '0;
            csum       <= '0;
            payload    <= '0;
        end else begin
            csum.valid    <= 1'b0;
            payload.valid <= 1'b0;
            if (in_rd_en && state == DISCARD) begin
                if (in_dout.eof) begin
                    // closing beat carries the error to the checksum.
                    csum  <= '{data: 8'h00, valid: 1'b1, twice: 1'b0,
                               cks_field: 1'b0, last: 1'b1, bad: 1'b1};
                    state <= IDLE;
                end
            end else if (in_rd_en && in_frame) begin
                if (cnt == 11'(udp_pkg::IP_TOTLEN_OFS)) begin
                    total_len[15:8] <= data;
                end
                if (cnt == 11'(udp_pkg::IP_TOTLEN_OFS + 1)) begin
                    total_len[7:0] <= data;
                end
                if (cnt == 11'(udp_pkg::UDP_LEN_OFS)) begin
                    udp_len_hi <= data;
                end
                if (fail) begin
                    cnt <= '0;
                    if (in_dout.eof) begin
                        csum  <= '{data: 8'h00, valid: 1'b1, twice: 1'b0,
                                   cks_field: 1'b0, last: 1'b1, bad: 1'b1};
                        state <= IDLE;
                    end else begin
                        state <= DISCARD;
                    end
                end else begin
                    // addresses onward go to the checksum.
                    csum.data      <= data;
                    csum.valid     <= (cnt >= 11'(udp_pkg::IP_SRC_OFS));
                    csum.twice     <= (cnt == 11'(udp_pkg::UDP_LEN_OFS)) ||
                                      (cnt == 11'(udp_pkg::UDP_LEN_OFS + 1));
                    csum.cks_field <= (cnt == 11'(udp_pkg::UDP_CKS_OFS)) ||
                                      (cnt == 11'(udp_pkg::UDP_CKS_OFS + 1));
                    csum.last      <= is_final;
                    csum.bad       <= 1'b0;
                    payload.data   <= data;
                    payload.valid  <= (state == PAYLOAD);
                    if (is_final) begin
                        state <= IDLE;
                        cnt   <= '0;
                    end else begin
                        state <= body_state;
                        cnt   <= cnt_inc;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 16
) (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   flush,
    input  logic   wr_en,
    input  entry_t din,
    output logic   full,
    input  logic   rd_en,
    output entry_t dout,
    output logic   empty
);

    localparam int ptr_w = $clog2(depth);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

    entry_t           mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == full_count);
    assign empty = (count == '0);

    // strobes against a full or empty buffer are dropped.
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head word is always on dout, rd_en pops it.
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: udp_pkg.sv
`default_nettype none

package udp_pkg;

    // buffer sizes.
    localparam int IN_FIFO_DEPTH = 16;
    // the output buffer also bounds the largest payload accepted.
    localparam int OUT_FIFO_DEPTH = 1024;

    // header sizes in bytes.
    localparam int IPV4_HDR_LEN = 20;
    localparam int UDP_HDR_LEN = 8;

    // expected header field values.
    localparam logic [7:0] IPV4_VER_IHL = 8'h45;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

    // byte offsets from the start of the IPv4 header.
    localparam int IP_TOTLEN_OFS = 2;
    localparam int IP_PROTO_OFS = 9;
    localparam int IP_SRC_OFS = 12;
    localparam int UDP_LEN_OFS = 24;
    localparam int UDP_CKS_OFS = 26;

    // one input byte with its frame markers.
    typedef struct packed {
        logic [7:0] data;
        logic       sof;
        logic       eof;
    } in_beat_t;

    // one byte toward the checksum stage.
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        // UDP length bytes, summed again for the pseudo-header.
        logic       twice;
        logic       cks_field;
        logic       last;
        logic       bad;
    } csum_beat_t;

    // one payload byte toward the gate.
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } pay_beat_t;

    // frame outcome, valid is a single-cycle pulse.
    typedef struct packed {
        logic valid;
        logic ok;
    } verdict_t;

endpackage

`default_nettype wire
